//--- src/sched_pkg.sv
// Scheduler shared definitions
`default_nettype none

package sched_pkg;

  // ==================================================
  // Sizes
  // ==================================================
  localparam int ARCH_REG_NUM = 32;
  localparam int PHY_REG_NUM  = 48;
  localparam int ROB_DEPTH    = 16;

  // Register and reorder buffer indices
  typedef logic [4:0]                     areg_t;
  typedef logic [$clog2(PHY_REG_NUM)-1:0] preg_t;
  typedef logic [$clog2(ROB_DEPTH)-1:0]   rob_idx_t;

  // ==================================================
  // Encodings
  // ==================================================
  typedef enum logic {
    FU_ALU = 1'b0,
    FU_MEM = 1'b1
  } fu_kind_e;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_LUI  = 4'd10
  } alu_op_e;

  // ==================================================
  // Bundles
  // ==================================================
  // Decoded instruction from the front end
  typedef struct packed {
    logic        valid;
    fu_kind_e    fu_kind;
    areg_t       src0;
    logic        src0_valid;
    areg_t       src1;
    logic        src1_valid;
    areg_t       dest;
    logic        dest_valid;
    alu_op_e     alu_op;
    logic        is_store;
    logic [31:0] imm;
    logic [31:0] pc;
  } sched_req_t;

  typedef struct packed {
    logic        valid;
    areg_t       arch_dest;
    logic        dest_valid;
    preg_t       pdest;
    preg_t       old_pdest;
    logic [31:0] pc;
  } rob_alloc_req_t;

  typedef struct packed {
    logic     ready;
    rob_idx_t rob_idx;
  } rob_alloc_rsp_t;

  // Common part of every issued instruction
  typedef struct packed {
    preg_t    psrc0;
    preg_t    psrc1;
    preg_t    pdest;
    logic     dest_valid;
    rob_idx_t rob_idx;
  } issue_hdr_t;

  typedef struct packed {
    alu_op_e     alu_op;
    logic [31:0] imm;
  } alu_payload_t;

  typedef struct packed {
    logic        is_store;
    logic [31:0] imm;
  } mem_payload_t;

endpackage

`default_nettype wire

//--- src/free_list.sv
// Physical register free list
`timescale 1ns/100ps
`default_nettype none

module free_list #(
  parameter int PHY_REG_NUM = sched_pkg::PHY_REG_NUM
) (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             flush_i,
  input  wire logic             pop_i,
  output logic                  empty_o,
  output sched_pkg::preg_t      preg_o,
  input  wire logic             commit_i,
  input  wire sched_pkg::preg_t free_preg_i
);

  localparam int FL_DEPTH = PHY_REG_NUM - sched_pkg::ARCH_REG_NUM;
  localparam int IDX_W    = $clog2(FL_DEPTH);
  localparam int CNT_W    = $clog2(FL_DEPTH + 1);

  sched_pkg::preg_t mem_q [FL_DEPTH];

  // Speculative head, committed head and push tail
  logic [IDX_W-1:0] head_q;
  logic [IDX_W-1:0] cmt_head_q;
  logic [IDX_W-1:0] tail_q;
  logic [CNT_W-1:0] cnt_q;

  function automatic logic [IDX_W-1:0] ptr_inc(input logic [IDX_W-1:0] p);
    ptr_inc = (p == IDX_W'(FL_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign empty_o = (cnt_q == '0);
  assign preg_o  = mem_q[head_q];

  // ==================================================
  // Pointer and storage update
  // ==================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q     <= '0;
      cmt_head_q <= '0;
      tail_q     <= '0;
      cnt_q      <= CNT_W'(FL_DEPTH);
      // Registers above the identity map start out free
      for (int i = 0; i < FL_DEPTH; i++) begin
        mem_q[i] <= sched_pkg::preg_t'(sched_pkg::ARCH_REG_NUM + i);
      end
    end else begin
      if (commit_i) begin
        mem_q[tail_q] <= free_preg_i;
        tail_q        <= ptr_inc(tail_q);
        cmt_head_q    <= ptr_inc(cmt_head_q);
      end
      if (flush_i) begin
        // Committed state always holds FL_DEPTH free entries
        head_q <= commit_i ? ptr_inc(cmt_head_q) : cmt_head_q;
        cnt_q  <= CNT_W'(FL_DEPTH);
      end else begin
        if (pop_i) begin
          head_q <= ptr_inc(head_q);
        end
        cnt_q <= cnt_q + CNT_W'(commit_i) - CNT_W'(pop_i);
      end
    end
  end

  // ==================================================
  // Checks
  // ==================================================
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!rst_n) pop_i |-> !empty_o
  );

  // A release needs an outstanding allocation behind it
  a_no_push_full: assert property (
    @(posedge clk) disable iff (!rst_n) commit_i |-> (cnt_q != CNT_W'(FL_DEPTH))
  );

endmodule

`default_nettype wire

//--- src/rename_table.sv
// Register alias table and ready bits
`timescale 1ns/100ps
`default_nettype none

module rename_table #(
  parameter int PHY_REG_NUM = sched_pkg::PHY_REG_NUM
) (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             flush_i,
  input  wire sched_pkg::preg_t [sched_pkg::ARCH_REG_NUM-1:0] arch_rat_i,
  input  wire sched_pkg::areg_t src0_i,
  input  wire sched_pkg::areg_t src1_i,
  input  wire sched_pkg::areg_t dest_i,
  input  wire logic             write_i,
  input  wire sched_pkg::preg_t new_preg_i,
  output sched_pkg::preg_t      psrc0_o,
  output sched_pkg::preg_t      psrc1_o,
  output sched_pkg::preg_t      old_pdest_o,
  output logic                  src0_rdy_o,
  output logic                  src1_rdy_o,
  input  wire logic             wb_valid_i,
  input  wire sched_pkg::preg_t wb_pdest_i
);

  sched_pkg::preg_t rat_q [sched_pkg::ARCH_REG_NUM];
  logic [PHY_REG_NUM-1:0] rdy_q;

  // ==================================================
  // Lookup
  // ==================================================
  assign psrc0_o     = rat_q[src0_i];
  assign psrc1_o     = rat_q[src1_i];
  assign old_pdest_o = rat_q[dest_i];

  // Writeback in this cycle counts as ready already
  assign src0_rdy_o = rdy_q[psrc0_o] | (wb_valid_i & (wb_pdest_i == psrc0_o));
  assign src1_rdy_o = rdy_q[psrc1_o] | (wb_valid_i & (wb_pdest_i == psrc1_o));

  // ==================================================
  // Map update
  // ==================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < sched_pkg::ARCH_REG_NUM; i++) begin
        rat_q[i] <= sched_pkg::preg_t'(i);
      end
    end else if (flush_i) begin
      for (int i = 0; i < sched_pkg::ARCH_REG_NUM; i++) begin
        rat_q[i] <= arch_rat_i[i];
      end
    end else if (write_i) begin
      rat_q[dest_i] <= new_preg_i;
    end
  end

  // Ready bits, cleared on allocation and set on writeback
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdy_q <= '1;
    end else if (flush_i) begin
      rdy_q <= '1;
    end else begin
      if (wb_valid_i) begin
        rdy_q[wb_pdest_i] <= 1'b1;
      end
      if (write_i) begin
        rdy_q[new_preg_i] <= 1'b0;
      end
    end
  end

  // A fresh register cannot be written back before it is handed out
  a_no_wb_on_alloc: assert property (
    @(posedge clk) disable iff (!rst_n)
      write_i |-> !(wb_valid_i && (wb_pdest_i == new_preg_i))
  );

endmodule

`default_nettype wire

//--- src/issue_queue.sv
// In-order issue queue with operand wakeup
`timescale 1ns/100ps
`default_nettype none

module issue_queue #(
  parameter int  DEPTH     = 4,
  parameter type payload_t = logic
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  flush_i,
  input  wire logic                  write_i,
  input  wire sched_pkg::issue_hdr_t hdr_i,
  input  wire logic                  src0_rdy_i,
  input  wire logic                  src1_rdy_i,
  input  wire payload_t              payload_i,
  output logic                       full_o,
  input  wire logic                  wb_valid_i,
  input  wire sched_pkg::preg_t      wb_pdest_i,
  output logic                       valid_o,
  input  wire logic                  ready_i,
  output sched_pkg::issue_hdr_t      hdr_o,
  output payload_t                   payload_o
);

  localparam int IDX_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  sched_pkg::issue_hdr_t hdr_q [DEPTH];
  payload_t              pl_q  [DEPTH];
  logic [DEPTH-1:0]      rdy0_q;
  logic [DEPTH-1:0]      rdy1_q;

  logic [IDX_W-1:0] wr_ptr_q;
  logic [IDX_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             pop;

  function automatic logic [IDX_W-1:0] ptr_inc(input logic [IDX_W-1:0] p);
    ptr_inc = (p == IDX_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // ==================================================
  // Head presentation
  // ==================================================
  assign full_o    = (cnt_q == CNT_W'(DEPTH));
  assign valid_o   = (cnt_q != '0) && rdy0_q[rd_ptr_q] && rdy1_q[rd_ptr_q];
  assign hdr_o     = hdr_q[rd_ptr_q];
  assign payload_o = pl_q[rd_ptr_q];
  assign pop       = valid_o & ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (write_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      cnt_q <= cnt_q + CNT_W'(write_i) - CNT_W'(pop);
    end
  end

  // ==================================================
  // Entry storage and wakeup
  // ==================================================
  always_ff @(posedge clk) begin
    for (int i = 0; i < DEPTH; i++) begin
      if (wb_valid_i && (hdr_q[i].psrc0 == wb_pdest_i)) begin
        rdy0_q[i] <= 1'b1;
      end
      if (wb_valid_i && (hdr_q[i].psrc1 == wb_pdest_i)) begin
        rdy1_q[i] <= 1'b1;
      end
    end
    // New entry takes its readiness from rename
    if (write_i) begin
      hdr_q[wr_ptr_q]  <= hdr_i;
      pl_q[wr_ptr_q]   <= payload_i;
      rdy0_q[wr_ptr_q] <= src0_rdy_i;
      rdy1_q[wr_ptr_q] <= src1_rdy_i;
    end
  end

  a_no_write_full: assert property (
    @(posedge clk) disable iff (!rst_n) write_i |-> !full_o
  );

  // Stalled head stays put until the unit takes it
  a_hold_head: assert property (
    @(posedge clk) disable iff (!rst_n)
      (valid_o && !ready_i && !flush_i) |=> (valid_o && $stable(hdr_o))
  );

endmodule

`default_nettype wire

//--- src/sched_ctrl.sv
// Rename stage control
`timescale 1ns/100ps
`default_nettype none

module sched_ctrl (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic                      flush_i,
  input  wire sched_pkg::sched_req_t     sched_req_i,
  output logic                           sched_ready_o,
  input  wire sched_pkg::rob_alloc_rsp_t rob_alloc_rsp_i,
  output sched_pkg::rob_alloc_req_t      rob_alloc_req_o,
  input  wire logic                      fl_empty_i,
  output logic                           fl_pop_o,
  input  wire sched_pkg::preg_t          fl_preg_i,
  input  wire sched_pkg::preg_t          rat_old_pdest_i,
  input  wire sched_pkg::preg_t          rat_psrc0_i,
  input  wire sched_pkg::preg_t          rat_psrc1_i,
  input  wire logic                      rat_src0_rdy_i,
  input  wire logic                      rat_src1_rdy_i,
  output logic                           rat_write_o,
  output sched_pkg::sched_req_t          stage_req_o,
  input  wire logic                      alu_full_i,
  input  wire logic                      mem_full_i,
  output logic                           alu_write_o,
  output logic                           mem_write_o,
  output sched_pkg::issue_hdr_t          wr_hdr_o,
  output logic                           wr_src0_rdy_o,
  output logic                           wr_src1_rdy_o,
  output sched_pkg::alu_payload_t        alu_payload_o,
  output sched_pkg::mem_payload_t        mem_payload_o
);

  sched_pkg::sched_req_t stage_q;
  sched_pkg::sched_req_t stage;
  logic                  stage_vld_q;
  logic                  tgt_full;
  logic                  fire;

  // ==================================================
  // Stage register
  // ==================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_vld_q <= 1'b0;
    end else if (flush_i) begin
      stage_vld_q <= 1'b0;
    end else if (sched_ready_o) begin
      stage_vld_q <= sched_req_i.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (sched_ready_o && sched_req_i.valid) begin
      stage_q <= sched_req_i;
    end
  end

  always_comb begin
    stage       = stage_q;
    stage.valid = stage_vld_q;
  end

  assign stage_req_o = stage;

  // Fire when ROB, free list and target queue can all take it
  assign tgt_full = (stage.fu_kind == sched_pkg::FU_MEM) ? mem_full_i : alu_full_i;
  assign fire = stage.valid && !flush_i && rob_alloc_rsp_i.ready &&
                (!fl_empty_i || !stage.dest_valid) && !tgt_full;

  assign sched_ready_o = !stage.valid || fire;
  assign fl_pop_o      = fire && stage.dest_valid;
  assign rat_write_o   = fire && stage.dest_valid;
  assign alu_write_o   = fire && (stage.fu_kind == sched_pkg::FU_ALU);
  assign mem_write_o   = fire && (stage.fu_kind == sched_pkg::FU_MEM);

  // ==================================================
  // ROB request and queue entry
  // ==================================================
  always_comb begin
    rob_alloc_req_o.valid      = stage.valid;
    rob_alloc_req_o.arch_dest  = stage.dest;
    rob_alloc_req_o.dest_valid = stage.dest_valid;
    rob_alloc_req_o.pdest      = fl_preg_i;
    rob_alloc_req_o.old_pdest  = rat_old_pdest_i;
    rob_alloc_req_o.pc         = stage.pc;

    wr_hdr_o.psrc0      = rat_psrc0_i;
    wr_hdr_o.psrc1      = rat_psrc1_i;
    wr_hdr_o.pdest      = fl_preg_i;
    wr_hdr_o.dest_valid = stage.dest_valid;
    wr_hdr_o.rob_idx    = rob_alloc_rsp_i.rob_idx;

    alu_payload_o.alu_op   = stage.alu_op;
    alu_payload_o.imm      = stage.imm;
    mem_payload_o.is_store = stage.is_store;
    mem_payload_o.imm      = stage.imm;
  end

  // Unused sources count as ready
  assign wr_src0_rdy_o = !stage.src0_valid || rat_src0_rdy_i;
  assign wr_src1_rdy_o = !stage.src1_valid || rat_src1_rdy_i;

  // Stalled instruction waits unchanged in the stage
  a_hold_stage: assert property (
    @(posedge clk) disable iff (!rst_n)
      (stage.valid && !fire && !flush_i) |=> (stage.valid && $stable(stage))
  );

endmodule

`default_nettype wire

//--- src/scheduler.sv
// Rename and dispatch scheduler
`timescale 1ns/100ps
`default_nettype none

module scheduler #(
  parameter int PHY_REG_NUM = sched_pkg::PHY_REG_NUM,
  parameter int ALU_DEPTH   = 4,
  parameter int MEM_DEPTH   = 4
) (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire sched_pkg::sched_req_t     sched_req_i,
  output logic                           sched_ready_o,
  output sched_pkg::rob_alloc_req_t      rob_alloc_req_o,
  input  wire sched_pkg::rob_alloc_rsp_t rob_alloc_rsp_i,
  input  wire logic                      commit_valid_i,
  input  wire logic                      commit_dest_valid_i,
  input  wire sched_pkg::preg_t          commit_old_preg_i,
  input  wire logic                      wb_valid_i,
  input  wire sched_pkg::preg_t          wb_pdest_i,
  input  wire logic                      flush_i,
  input  wire sched_pkg::preg_t [sched_pkg::ARCH_REG_NUM-1:0] arch_rat_i,
  input  wire logic                      alu_ready_i,
  output logic                           alu_valid_o,
  output sched_pkg::issue_hdr_t          alu_hdr_o,
  output sched_pkg::alu_payload_t        alu_payload_o,
  input  wire logic                      mem_ready_i,
  output logic                           mem_valid_o,
  output sched_pkg::issue_hdr_t          mem_hdr_o,
  output sched_pkg::mem_payload_t        mem_payload_o
);

  sched_pkg::sched_req_t   stage_req;
  sched_pkg::preg_t        fl_preg;
  sched_pkg::preg_t        rat_old_pdest;
  sched_pkg::preg_t        rat_psrc0;
  sched_pkg::preg_t        rat_psrc1;
  sched_pkg::issue_hdr_t   wr_hdr;
  sched_pkg::alu_payload_t alu_wr_payload;
  sched_pkg::mem_payload_t mem_wr_payload;
  logic fl_empty;
  logic fl_pop;
  logic rat_src0_rdy;
  logic rat_src1_rdy;
  logic rat_write;
  logic alu_full;
  logic mem_full;
  logic alu_write;
  logic mem_write;
  logic wr_src0_rdy;
  logic wr_src1_rdy;

  // ==================================================
  // Rename stage
  // ==================================================
  sched_ctrl u_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .flush_i         (flush_i),
    .sched_req_i     (sched_req_i),
    .sched_ready_o   (sched_ready_o),
    .rob_alloc_rsp_i (rob_alloc_rsp_i),
    .rob_alloc_req_o (rob_alloc_req_o),
    .fl_empty_i      (fl_empty),
    .fl_pop_o        (fl_pop),
    .fl_preg_i       (fl_preg),
    .rat_old_pdest_i (rat_old_pdest),
    .rat_psrc0_i     (rat_psrc0),
    .rat_psrc1_i     (rat_psrc1),
    .rat_src0_rdy_i  (rat_src0_rdy),
    .rat_src1_rdy_i  (rat_src1_rdy),
    .rat_write_o     (rat_write),
    .stage_req_o     (stage_req),
    .alu_full_i      (alu_full),
    .mem_full_i      (mem_full),
    .alu_write_o     (alu_write),
    .mem_write_o     (mem_write),
    .wr_hdr_o        (wr_hdr),
    .wr_src0_rdy_o   (wr_src0_rdy),
    .wr_src1_rdy_o   (wr_src1_rdy),
    .alu_payload_o   (alu_wr_payload),
    .mem_payload_o   (mem_wr_payload)
  );

  free_list #(
    .PHY_REG_NUM (PHY_REG_NUM)
  ) u_free_list (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush_i),
    .pop_i       (fl_pop),
    .empty_o     (fl_empty),
    .preg_o      (fl_preg),
    .commit_i    (commit_valid_i & commit_dest_valid_i),
    .free_preg_i (commit_old_preg_i)
  );

  rename_table #(
    .PHY_REG_NUM (PHY_REG_NUM)
  ) u_rename_table (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush_i),
    .arch_rat_i  (arch_rat_i),
    .src0_i      (stage_req.src0),
    .src1_i      (stage_req.src1),
    .dest_i      (stage_req.dest),
    .write_i     (rat_write),
    .new_preg_i  (fl_preg),
    .psrc0_o     (rat_psrc0),
    .psrc1_o     (rat_psrc1),
    .old_pdest_o (rat_old_pdest),
    .src0_rdy_o  (rat_src0_rdy),
    .src1_rdy_o  (rat_src1_rdy),
    .wb_valid_i  (wb_valid_i),
    .wb_pdest_i  (wb_pdest_i)
  );

  // ==================================================
  // Issue queues
  // ==================================================
  issue_queue #(
    .DEPTH     (ALU_DEPTH),
    .payload_t (sched_pkg::alu_payload_t)
  ) u_alu_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush_i),
    .write_i    (alu_write),
    .hdr_i      (wr_hdr),
    .src0_rdy_i (wr_src0_rdy),
    .src1_rdy_i (wr_src1_rdy),
    .payload_i  (alu_wr_payload),
    .full_o     (alu_full),
    .wb_valid_i (wb_valid_i),
    .wb_pdest_i (wb_pdest_i),
    .valid_o    (alu_valid_o),
    .ready_i    (alu_ready_i),
    .hdr_o      (alu_hdr_o),
    .payload_o  (alu_payload_o)
  );

  issue_queue #(
    .DEPTH     (MEM_DEPTH),
    .payload_t (sched_pkg::mem_payload_t)
  ) u_mem_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush_i),
    .write_i    (mem_write),
    .hdr_i      (wr_hdr),
    .src0_rdy_i (wr_src0_rdy),
    .src1_rdy_i (wr_src1_rdy),
    .payload_i  (mem_wr_payload),
    .full_o     (mem_full),
    .wb_valid_i (wb_valid_i),
    .wb_pdest_i (wb_pdest_i),
    .valid_o    (mem_valid_o),
    .ready_i    (mem_ready_i),
    .hdr_o      (mem_hdr_o),
    .payload_o  (mem_payload_o)
  );

endmodule

`default_nettype wire

//--- tb/sched_vectors.svh
// Scheduler test vectors
`ifndef SCHED_VECTORS_SVH
`define SCHED_VECTORS_SVH

// Row fields in order are name, request, flags {flush,rob,alu,mem}, wb, commit,
// sready, alu pdest/psrc0/imm, mem pdest/psrc0/imm, rob old_pdest and gap
// A value of -1 leaves a field unused and a mem pdest of -2 marks a store
task automatic load_vectors();
  // Independent renames
  add_row("indep", make_instr(0, 1, 2, 3, 1, 1), 4'h7, -1, -1, 1, -1, 0, 0, -1, 0, 0, -1, 0);
  add_row("indep", make_instr(0, 4, 5, 6, 1, 2), 4'h7, -1, -1, 1, -1, 0, 0, -1, 0, 0, 3, 0);
  add_row("indep", no_instr(), 4'h7, -1, -1, 1, 32, 1, 1, -1, 0, 0, 6, 0);
  add_row("indep", no_instr(), 4'h7, -1, -1, 1, 33, 4, 2, -1, 0, 0, -1, 1);
  // Dependency on r3 woken by writeback of 32
  add_row("dep", make_instr(0, 3, 0, 7, 1, 3), 4'h7, -1, -1, 1, -1, 0, 0, -1, 0, 0, -1, 0);
  add_row("dep", no_instr(), 4'h7, -1, -1, 1, -1, 0, 0, -1, 0, 0, 7, 0);
  add_row("dep", no_instr(), 4'h7, -1, -1, 1, -1, 0, 0, -1, 0, 0, -1, 0);
  add_row("dep", no_instr(), 4'h7, -1, -1, 1, -1, 0, 0, -1, 0, 0, -1, 0);
  add_row("dep", no_instr(), 4'h7, 32, -1, 1, -1, 0, 0, -1, 0, 0, -1, 0);
  add_row("dep", no_instr(), 4'h7, -1, -1, 1, 34, 32, 3, -1, 0, 0, -1, 1);
  // Routing with the ALU unit stalled
  add_row("route", make_instr(0, 1, 2, 8, 1, 4), 4'h5, -1, -1, 1, -1, 0, 0, -1, 0, 0, -1, 0);
  add_row("route", make_instr(1, 2, 1, 9, 1, 5), 4'h5, -1, -1, 1, -1, 0, 0, -1, 0, 0, 8, 0);
  add_row("route", make_instr(0, 1, 1, 10, 1, 6), 4'h5, -1, -1, 1, 35, 1, 4, -1, 0, 0, 9, 0);
  add_row("route", make_instr(1, 1, 2, 0, 0, 7), 4'h5, -1, -1, 1, 35, 1, 4, 36, 2, 5, 10, 0);
  add_row("route", no_instr(), 4'h5, -1, -1, 1, 35, 1, 4, -1, 0, 0, -1, 0);
  add_row("route", no_instr(), 4'h5, -1, -1, 1, 35, 1, 4, -2, 1, 7, -1, 0);
  add_row("route", no_instr(), 4'h7, -1, -1, 1, 35, 1, 4, -1, 0, 0, -1, 0);
  add_row("route", no_instr(), 4'h7, -1, -1, 1, 37, 1, 6, -1, 0, 0, -1, 0);
  add_row("route", no_instr(), 4'h7, -1, -1, 1, -1, 0, 0, -1, 0, 0, -1, 1);
  // Free list runs dry until a commit of 5 refills it
  add_row("exhaust", make_instr(0, 0, 0, 12, 1, 10), 4'h7, -1, -1, 1, -1, 0, 0, -1, 0, 0, -1, 0);
  add_row("exhaust", make_instr(0, 0, 0, 13, 1, 11), 4'h7, -1, -1, 1, -1, 0, 0, -1, 0, 0, 12, 0);
  add_row("exhaust", make_instr(0, 0, 0, 14, 1, 12), 4'h7, -1, -1, 1, 38, 0, 10, -1, 0, 0, 13, 0);
  add_row("exhaust", make_instr(0, 0, 0, 15, 1, 13), 4'h7, -1, -1, 1, 39, 0, 11, -1, 0, 0, 14, 0);
  add_row("exhaust", make_instr(0, 0, 0, 16, 1, 14), 4'h7, -1, -1, 1, 40, 0, 12, -1, 0, 0, 15, 0);
  add_row("exhaust", make_instr(0, 0, 0, 17, 1, 15), 4'h7, -1, -1, 1, 41, 0, 13, -1, 0, 0, 16, 0);
  add_row("exhaust", make_instr(0, 0, 0, 18, 1, 16), 4'h7, -1, -1, 1, 42, 0, 14, -1, 0, 0, 17, 0);
  add_row("exhaust", make_instr(0, 0, 0, 19, 1, 17), 4'h7, -1, -1, 1, 43, 0, 15, -1, 0, 0, 18, 0);
  add_row("exhaust", make_instr(0, 0, 0, 20, 1, 18), 4'h7, -1, -1, 1, 44, 0, 16, -1, 0, 0, 19, 0);
  add_row("exhaust", make_instr(0, 0, 0, 21, 1, 19), 4'h7, -1, -1, 1, 45, 0, 17, -1, 0, 0, 20, 0);
  add_row("exhaust", make_instr(0, 0, 0, 22, 1, 20), 4'h7, -1, -1, 1, 46, 0, 18, -1, 0, 0, 21, 0);
  add_row("exhaust", make_instr(0, 0, 0, 23, 1, 21), 4'h7, -1, -1, 0, 47, 0, 19, -1, 0, 0, 22, 0);
  add_row("exhaust", make_instr(0, 0, 0, 23, 1, 21), 4'h7, -1, 5, 0, -1, 0, 0, -1, 0, 0, 22, 0);
  add_row("exhaust", make_instr(0, 0, 0, 23, 1, 21), 4'h7, -1, -1, 1, -1, 0, 0, -1, 0, 0, 22, 0);
  add_row("exhaust", no_instr(), 4'h7, -1, -1, 0, 5, 0, 20, -1, 0, 0, 23, 0);
  // Flush drops the stage and any queued entries
  add_row("flush", no_instr(), 4'hf, -1, -1, 0, -1, 0, 0, -1, 0, 0, 23, 0);
  add_row("flush", make_instr(0, 1, 0, 2, 1, 30), 4'h7, -1, -1, 1, -1, 0, 0, -1, 0, 0, -1, 0);
  add_row("flush", make_instr(1, 2, 0, 0, 0, 31), 4'h6, -1, -1, 1, -1, 0, 0, -1, 0, 0, 2, 0);
  add_row("flush", make_instr(1, 0, 0, 0, 0, 32), 4'h6, -1, -1, 1, 33, 44, 30, -1, 0, 0, -1, 0);
  add_row("flush", no_instr(), 4'h6, -1, -1, 1, -1, 0, 0, -1, 0, 0, -1, 0);
  add_row("flush", no_instr(), 4'he, -1, -1, 1, -1, 0, 0, -1, 0, 0, -1, 0);
  add_row("flush", no_instr(), 4'h7, 33, -1, 1, -1, 0, 0, -1, 0, 0, -1, 0);
  add_row("flush", no_instr(), 4'h7, -1, -1, 1, -1, 0, 0, -1, 0, 0, -1, 1);
  // ROB not ready holds the stage
  add_row("rob_stall", make_instr(0, 1, 0, 4, 1, 40), 4'h7, -1, -1, 1, -1, 0, 0, -1, 0, 0, -1, 0);
  add_row("rob_stall", make_instr(0, 0, 0, 5, 1, 41), 4'h3, -1, -1, 0, -1, 0, 0, -1, 0, 0, 4, 0);
  add_row("rob_stall", make_instr(0, 0, 0, 5, 1, 41), 4'h3, -1, -1, 0, -1, 0, 0, -1, 0, 0, 4, 0);
  add_row("rob_stall", make_instr(0, 0, 0, 5, 1, 41), 4'h7, -1, -1, 1, -1, 0, 0, -1, 0, 0, 4, 0);
  add_row("rob_stall", no_instr(), 4'h7, -1, -1, 1, 33, 44, 40, -1, 0, 0, 5, 0);
  add_row("rob_stall", no_instr(), 4'h7, -1, -1, 1, 34, 0, 41, -1, 0, 0, -1, 0);
  add_row("rob_stall", no_instr(), 4'h7, -1, -1, 1, -1, 0, 0, -1, 0, 0, -1, 0);
endtask

`endif

//--- tb/scheduler_tb.sv
// Scheduler testbench
`timescale 1ns/100ps
`default_nettype none

module scheduler_tb;

  typedef struct {
    string                 name;
    sched_pkg::sched_req_t req;
    logic [3:0]            flags;
    int                    wb;
    int                    cmt;
    logic                  sready;
    int                    alu_pd;
    int                    alu_ps0;
    int                    alu_imm;
    int                    mem_pd;
    int                    mem_ps0;
    int                    mem_imm;
    int                    old;
    logic                  gap;
  } vec_t;

  logic clk;
  logic rst_n;
  sched_pkg::sched_req_t     req;
  logic                      sched_ready;
  sched_pkg::rob_alloc_req_t rob_req;
  sched_pkg::rob_alloc_rsp_t rob_rsp;
  logic                      rob_ready;
  logic [3:0]                rob_cnt;
  logic commit_valid;
  logic commit_dest_valid;
  sched_pkg::preg_t commit_old;
  logic wb_valid;
  sched_pkg::preg_t wb_pdest;
  logic flush;
  sched_pkg::preg_t [sched_pkg::ARCH_REG_NUM-1:0] arch_rat;
  logic alu_ready;
  logic alu_valid;
  sched_pkg::issue_hdr_t   alu_hdr;
  sched_pkg::alu_payload_t alu_payload;
  logic mem_ready;
  logic mem_valid;
  sched_pkg::issue_hdr_t   mem_hdr;
  sched_pkg::mem_payload_t mem_payload;

  vec_t vecs[$];
  int   idx_of [64];
  logic loaded;

  scheduler #(
    .PHY_REG_NUM (48),
    .ALU_DEPTH   (4),
    .MEM_DEPTH   (4)
  ) UUT (
    .clk                 (clk),
    .rst_n               (rst_n),
    .sched_req_i         (req),
    .sched_ready_o       (sched_ready),
    .rob_alloc_req_o     (rob_req),
    .rob_alloc_rsp_i     (rob_rsp),
    .commit_valid_i      (commit_valid),
    .commit_dest_valid_i (commit_dest_valid),
    .commit_old_preg_i   (commit_old),
    .wb_valid_i          (wb_valid),
    .wb_pdest_i          (wb_pdest),
    .flush_i             (flush),
    .arch_rat_i          (arch_rat),
    .alu_ready_i         (alu_ready),
    .alu_valid_o         (alu_valid),
    .alu_hdr_o           (alu_hdr),
    .alu_payload_o       (alu_payload),
    .mem_ready_i         (mem_ready),
    .mem_valid_o         (mem_valid),
    .mem_hdr_o           (mem_hdr),
    .mem_payload_o       (mem_payload)
  );

  always #50 clk = ~clk;

  // ==================================================
  // ROB stand-in
  // ==================================================
  always_comb begin
    rob_rsp.ready   = rob_ready;
    rob_rsp.rob_idx = rob_cnt;
  end

  // Index handed out per instruction and keyed by its pc
  always @(posedge clk) begin
    if (rst_n && rob_req.valid && rob_ready) begin
      idx_of[rob_req.pc[5:0]] <= int'(rob_cnt);
      rob_cnt <= rob_cnt + 4'd1;
    end
  end

  // ==================================================
  // Table helpers
  // ==================================================
  function automatic sched_pkg::sched_req_t make_instr(input logic is_mem, input int s0,
      input int s1, input int d, input logic dv, input int imm);
    sched_pkg::sched_req_t r;
    r            = '0;
    r.valid      = 1'b1;
    r.fu_kind    = is_mem ? sched_pkg::FU_MEM : sched_pkg::FU_ALU;
    r.src0       = sched_pkg::areg_t'(s0);
    r.src0_valid = 1'b1;
    r.src1       = sched_pkg::areg_t'(s1);
    r.src1_valid = 1'b1;
    r.dest       = sched_pkg::areg_t'(d);
    r.dest_valid = dv;
    r.alu_op     = sched_pkg::ALU_ADD;
    r.is_store   = is_mem && !dv;
    r.imm        = imm;
    r.pc         = imm;
    return r;
  endfunction

  function automatic sched_pkg::sched_req_t no_instr();
    return '0;
  endfunction

  task automatic add_row(input string name, input sched_pkg::sched_req_t r,
      input logic [3:0] flags, input int wb, input int cmt, input logic sready,
      input int alu_pd, input int alu_ps0, input int alu_imm,
      input int mem_pd, input int mem_ps0, input int mem_imm,
      input int old, input logic gap);
    vec_t v;
    v.name = name;
    v.req = r;
    v.flags = flags;
    v.wb = wb;
    v.cmt = cmt;
    v.sready = sready;
    v.alu_pd = alu_pd;
    v.alu_ps0 = alu_ps0;
    v.alu_imm = alu_imm;
    v.mem_pd = mem_pd;
    v.mem_ps0 = mem_ps0;
    v.mem_imm = mem_imm;
    v.old = old;
    v.gap = gap;
    vecs.push_back(v);
  endtask

  `include "sched_vectors.svh"

  task automatic check_value(input string name, input string what, input int expected,
      input int actual);
    if (expected != actual) begin
      $display("Fail %s %s: expected %0d, actual %0d", name, what, expected, actual);
      $display("Finished with errors");
      $fatal(1);
    end
  endtask

  task automatic apply_row(input vec_t v);
    req               <= v.req;
    {flush, rob_ready, alu_ready, mem_ready} <= v.flags;
    wb_valid          <= (v.wb >= 0);
    wb_pdest          <= sched_pkg::preg_t'((v.wb >= 0) ? v.wb : 0);
    commit_valid      <= (v.cmt >= 0);
    commit_dest_valid <= (v.cmt >= 0);
    commit_old        <= sched_pkg::preg_t'((v.cmt >= 0) ? v.cmt : 0);
  endtask

  task automatic drive_idle();
    req               <= '0;
    {flush, rob_ready, alu_ready, mem_ready} <= 4'h7;
    wb_valid          <= 1'b0;
    commit_valid      <= 1'b0;
    commit_dest_valid <= 1'b0;
  endtask

  task automatic check_outputs(input vec_t v);
    check_value(v.name, "sched_ready", int'(v.sready), int'(sched_ready));
    check_value(v.name, "alu_valid", int'(v.alu_pd != -1), int'(alu_valid));
    if (v.alu_pd != -1) begin
      check_value(v.name, "alu pdest", v.alu_pd, int'(alu_hdr.pdest));
      check_value(v.name, "alu psrc0", v.alu_ps0, int'(alu_hdr.psrc0));
      check_value(v.name, "alu imm", v.alu_imm, int'(alu_payload.imm));
      check_value(v.name, "alu rob_idx", idx_of[v.alu_imm], int'(alu_hdr.rob_idx));
    end
    check_value(v.name, "mem_valid", int'(v.mem_pd != -1), int'(mem_valid));
    if (v.mem_pd != -1) begin
      if (v.mem_pd != -2) begin
        check_value(v.name, "mem pdest", v.mem_pd, int'(mem_hdr.pdest));
      end
      check_value(v.name, "mem psrc0", v.mem_ps0, int'(mem_hdr.psrc0));
      check_value(v.name, "mem imm", v.mem_imm, int'(mem_payload.imm));
      check_value(v.name, "mem is_store", int'(v.mem_pd == -2), int'(mem_payload.is_store));
    end
    if (v.old != -1) begin
      check_value(v.name, "rob valid", 1, int'(rob_req.valid));
      check_value(v.name, "rob old_pdest", v.old, int'(rob_req.old_pdest));
    end
  endtask

  // ==================================================
  // Main sequence
  // ==================================================
  initial begin
    int seed;
    int gap;
    seed = 32'heed8_5f26;
    void'($urandom(seed));
    clk = 1'b0;
    rst_n = 1'b0;
    loaded = 1'b0;
    rob_cnt = '0;
    req = '0;
    rob_ready = 1'b1;
    commit_valid = 1'b0;
    commit_dest_valid = 1'b0;
    commit_old = '0;
    wb_valid = 1'b0;
    wb_pdest = '0;
    flush = 1'b0;
    alu_ready = 1'b1;
    mem_ready = 1'b1;
    // Committed map used on flush with r1 moved off the identity map
    for (int i = 0; i < sched_pkg::ARCH_REG_NUM; i++) begin
      arch_rat[i] = sched_pkg::preg_t'(i);
    end
    arch_rat[1] = sched_pkg::preg_t'(44);
    load_vectors();
    loaded = 1'b1;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    foreach (vecs[i]) begin
      @(posedge clk);
      apply_row(vecs[i]);
      @(negedge clk);
      check_outputs(vecs[i]);
      if (vecs[i].gap) begin
        gap = int'($urandom % 4);
        repeat (gap) begin
          @(posedge clk);
          drive_idle();
        end
      end
    end
    $display("Finished with no errors");
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    wait (loaded);
    #(vecs.size() * 20 * 100);
    $display("Timeout: the test table did not complete in time");
    $display("Finished with errors");
    $fatal(1);
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+tb
src/sched_pkg.sv
src/free_list.sv
src/rename_table.sv
src/issue_queue.sv
src/sched_ctrl.sv
src/scheduler.sv
tb/scheduler_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f sim.f --top-module scheduler_tb \
  --Mdir obj_dir -o scheduler_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Build failed with status $status"
  exit 1
fi

output=$(./obj_dir/scheduler_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Finished with no errors"; then
  exit 0
fi
exit 1
